// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing -Wno-fatal
TOP       := tb_sd_dat_rx
FILELIST  := src.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED

SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/sd_dat_cfg.svh
`ifndef SD_DAT_CFG_SVH
`define SD_DAT_CFG_SVH

// Width of the block size in bytes, so at most 4095 bytes per block
`define SD_MAX_BLOCK_BITS 12

// CRC16-CCITT, x^16 + x^12 + x^5 + 1
`define SD_CRC16_POLY 16'h1021

`endif

// File: rtl/crc16_line.sv
`timescale 1ns/100ps
`include "sd_dat_cfg.svh"

module crc16_line (
  input  logic        sd_clk_i,
  input  logic        rst_i,
  input  logic        clear_i,
  input  logic        bit_i,
  output logic [15:0] crc_o
);
  logic [15:0] crc_q;
  logic [15:0] crc_d;
  logic        feedback;

  // MSB first division, data followed by its own CRC leaves zero
  assign feedback = crc_q[15] ^ bit_i;

  always_comb begin
    crc_d = {crc_q[14:0], 1'b0};
    if (feedback) begin
      crc_d = crc_d ^ `SD_CRC16_POLY;
    end
  end

  always_ff @(posedge sd_clk_i) begin
    if (rst_i) begin
      crc_q <= '0;
    end else if (clear_i) begin
      crc_q <= '0;
    end else begin
      crc_q <= crc_d;
    end
  end

  assign crc_o = crc_q;

endmodule

// File: rtl/dat_read.sv
`timescale 1ns/100ps
`include "sd_dat_cfg.svh"

module dat_read #(
  parameter int MaxBlockBitSize = `SD_MAX_BLOCK_BITS
) (
  input  logic                       sd_clk_i,
  input  logic                       rst_i,
  input  logic [3:0]                 dat_i,
  input  logic                       start_i,
  input  logic [MaxBlockBitSize-1:0] block_size_i,
  output sd_dat_pkg::rx_word_t       word_o,
  output sd_dat_pkg::rx_status_t     result_o
);
  // Counts nibbles through data and CRC, up to 2 * size + 16
  localparam int CounterWidth = MaxBlockBitSize + 2;

  typedef enum logic [2:0] {
    IDLE,
    READY,
    DAT,
    CRC,
    END_BIT
  } rx_state_e;

  rx_state_e               state_q;
  rx_state_e               state_d;
  logic [CounterWidth-1:0] counter_q;
  logic [CounterWidth-1:0] counter_d;
  logic [CounterWidth-1:0] data_last;
  logic [CounterWidth-1:0] crc_last;

  // Payload, high nibble of the byte in flight and the bytes shifted in so far
  logic [3:0]  hi_nib_q;
  logic [3:0]  hi_nib_d;
  logic [31:0] word_q;
  logic [31:0] word_d;

  logic        clear_crc;
  logic [3:0]  crc_bad;

  assign data_last = {1'b0, block_size_i, 1'b0} - 1'b1;
  assign crc_last  = data_last + CounterWidth'(16);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start_i) state_d = READY;
      READY:   if (dat_i == 4'b0000) state_d = DAT;
      DAT:     if (counter_q == data_last) state_d = CRC;
      CRC:     if (counter_q == crc_last) state_d = END_BIT;
      END_BIT: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_comb begin
    counter_d   = counter_q;
    hi_nib_d    = hi_nib_q;
    word_d      = word_q;
    clear_crc   = 1'b0;
    word_o      = '0;
    result_o    = '0;

    case (state_q)
      READY: begin
        // Engines stay at zero until the start bit, data starts the cycle after
        counter_d = '0;
        clear_crc = 1'b1;
      end
      DAT: begin
        counter_d = counter_q + 1'b1;
        if (!counter_q[0]) begin
          hi_nib_d = dat_i;
        end else begin
          // Byte complete, shift it in from the top so the first byte ends low
          word_d = {hi_nib_q, dat_i, word_q[31:8]};
          if (counter_q[2:0] == 3'b111) begin
            word_o.valid = 1'b1;
            word_o.data  = {hi_nib_q, dat_i, word_q[31:8]};
          end
        end
      end
      CRC: begin
        counter_d = counter_q + 1'b1;
      end
      END_BIT: begin
        result_o.done        = 1'b1;
        result_o.crc_err     = |crc_bad;
        result_o.end_bit_err = dat_i != 4'b1111;

        // Leftover bytes sit at the top of word_q
        case (block_size_i[1:0])
          2'd1: word_o.data = {24'b0, word_q[31:24]};
          2'd2: word_o.data = {16'b0, word_q[31:16]};
          2'd3: word_o.data = {8'b0, word_q[31:8]};
          default: word_o.data = '0;
        endcase
        word_o.valid = block_size_i[1:0] != 2'd0;
      end
      default: ;
    endcase
  end

  always_ff @(posedge sd_clk_i) begin
    if (rst_i) begin
      state_q   <= IDLE;
      counter_q <= '0;
    end else begin
      state_q   <= state_d;
      counter_q <= counter_d;
    end
  end

  always_ff @(posedge sd_clk_i) begin
    hi_nib_q <= hi_nib_d;
    word_q   <= word_d;
  end

  // One engine per DAT line
  for (genvar i = 0; i < 4; i++) begin : g_crc
    logic [15:0] line_crc;

    crc16_line i_crc16_line (
      .sd_clk_i (sd_clk_i),
      .rst_i    (rst_i),
      .clear_i  (clear_crc),
      .bit_i    (dat_i[i]),
      .crc_o    (line_crc)
    );

    assign crc_bad[i] = line_crc != 16'h0000;
  end

endmodule

// File: rtl/sd_dat_pkg.sv
`include "sd_dat_cfg.svh"

package sd_dat_pkg;

  // One received 32-bit word, first byte in bits 7:0
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } rx_word_t;

  // Block result, the error flags only mean something while done is set
  typedef struct packed {
    logic done;
    logic crc_err;
    logic end_bit_err;
  } rx_status_t;

  // Words per block, a full block of bytes divided by four needs one extra bit
  localparam int WordCntBits = `SD_MAX_BLOCK_BITS - 2 + 1;

  typedef logic [WordCntBits-1:0] word_cnt_t;

endpackage

// File: rtl/sd_dat_rx_top.sv
`timescale 1ns/100ps
`include "sd_dat_cfg.svh"

module sd_dat_rx_top (
  input  logic                          sd_clk_i,
  input  logic                          rst_i,
  input  logic [3:0]                    dat_i,
  input  logic                          start_i,
  input  logic [`SD_MAX_BLOCK_BITS-1:0] block_size_i,
  output sd_dat_pkg::rx_word_t          word_o,
  output sd_dat_pkg::word_cnt_t         word_count_o,
  output sd_dat_pkg::rx_status_t        status_o
);
  import sd_dat_pkg::*;

  // Done pulse with its flags, only valid for one cycle
  rx_status_t result;

  dat_read #(
    .MaxBlockBitSize (`SD_MAX_BLOCK_BITS)
  ) i_dat_read (
    .sd_clk_i     (sd_clk_i),
    .rst_i        (rst_i),
    .dat_i        (dat_i),
    .start_i      (start_i),
    .block_size_i (block_size_i),
    .word_o       (word_o),
    .result_o     (result)
  );

  sd_rx_status i_sd_rx_status (
    .sd_clk_i     (sd_clk_i),
    .rst_i        (rst_i),
    .start_i      (start_i),
    .word_i       (word_o),
    .result_i     (result),
    .word_count_o (word_count_o),
    .status_o     (status_o)
  );

endmodule

// File: rtl/sd_rx_status.sv
`timescale 1ns/100ps

module sd_rx_status (
  input  logic                   sd_clk_i,
  input  logic                   rst_i,
  input  logic                   start_i,
  input  sd_dat_pkg::rx_word_t   word_i,
  input  sd_dat_pkg::rx_status_t result_i,
  output sd_dat_pkg::word_cnt_t  word_count_o,
  output sd_dat_pkg::rx_status_t status_o
);
  import sd_dat_pkg::*;

  logic       active_q;
  word_cnt_t  count_q;
  rx_status_t status_q;

  // Open from start until the done pulse, the flushed word still counts
  always_ff @(posedge sd_clk_i) begin
    if (rst_i) begin
      active_q <= 1'b0;
    end else if (start_i) begin
      active_q <= 1'b1;
    end else if (result_i.done) begin
      active_q <= 1'b0;
    end
  end

  always_ff @(posedge sd_clk_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (start_i) begin
      count_q <= '0;
    end else if (active_q && word_i.valid) begin
      count_q <= count_q + 1'b1;
    end
  end

  // Sticky result, held until the next block starts
  always_ff @(posedge sd_clk_i) begin
    if (rst_i) begin
      status_q <= '0;
    end else if (start_i) begin
      status_q <= '0;
    end else if (result_i.done) begin
      status_q <= result_i;
    end
  end

  assign word_count_o = count_q;
  assign status_o     = status_q;

endmodule

// File: src.f
+incdir+include
rtl/sd_dat_pkg.sv
rtl/crc16_line.sv
rtl/dat_read.sv
rtl/sd_rx_status.sv
rtl/sd_dat_rx_top.sv
tests/sd_card_model.sv
tests/tb_sd_dat_rx.sv

// File: tests/sd_card_model.sv
`timescale 1ns/100ps
`include "sd_dat_cfg.svh"

module sd_card_model #(
  parameter int MaxBytes = 64
) (
  input  logic       clk_i,
  input  logic       send_i,
  input  logic [7:0] bytes_i [MaxBytes],
  input  int         size_i,
  input  int         gap_i,
  input  logic       crc_flip_i,
  input  logic [1:0] crc_line_i,
  input  logic       bad_end_i,
  output logic [3:0] dat_o,
  output logic       busy_o
);
  logic [15:0] line_crc [4];

  // One CRC16-CCITT step, MSB first
  function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic bit_in);
    logic [15:0] shifted;
    shifted = {crc[14:0], 1'b0};
    if (crc[15] ^ bit_in) begin
      shifted = shifted ^ `SD_CRC16_POLY;
    end
    return shifted;
  endfunction

  // Holds a nibble on the lines for one clock
  task automatic put_nibble(input logic [3:0] nib);
    dat_o <= nib;
    @(posedge clk_i);
  endtask

  task automatic put_data_nibble(input logic [3:0] nib);
    for (int l = 0; l < 4; l++) begin
      line_crc[l] = crc_step(line_crc[l], nib[l]);
    end
    put_nibble(nib);
  endtask

  initial begin
    logic [3:0] nib;
    dat_o  = 4'hF;
    busy_o = 1'b0;
    forever begin
      @(posedge clk_i);
      if (send_i) begin
        busy_o <= 1'b1;
        for (int l = 0; l < 4; l++) begin
          line_crc[l] = '0;
        end
        repeat (gap_i) put_nibble(4'hF);
        // Start bit on all four lines
        put_nibble(4'h0);
        for (int k = 0; k < size_i; k++) begin
          put_data_nibble(bytes_i[k][7:4]);
          put_data_nibble(bytes_i[k][3:0]);
        end
        // CRC goes out MSB first, the chosen line gets one bit flipped
        for (int j = 0; j < 16; j++) begin
          for (int l = 0; l < 4; l++) begin
            nib[l] = line_crc[l][15-j];
            if (crc_flip_i && l == int'(crc_line_i) && j == 4 * int'(crc_line_i)) begin
              nib[l] = ~nib[l];
            end
          end
          put_nibble(nib);
        end
        put_nibble(bad_end_i ? 4'b1101 : 4'b1111);
        dat_o  <= 4'hF;
        busy_o <= 1'b0;
      end
    end
  end

endmodule

// File: tests/tb_sd_dat_rx.sv
`timescale 1ns/100ps
`include "sd_dat_cfg.svh"

module tb_sd_dat_rx;
  import sd_dat_pkg::*;

  localparam int ClkPeriod   = 10;
  localparam int ResetCycles = 16;
  localparam int MaxBytes    = 64;
  localparam int NumRows     = 13;
  localparam int SeedBase    = 89962;

  // crc_line also selects which CRC cycle gets the flipped bit
  typedef struct packed {
    logic [`SD_MAX_BLOCK_BITS-1:0] size;
    logic [15:0]                   seed;
    logic [7:0]                    gap;
    logic                          crc_flip;
    logic [1:0]                    crc_line;
    logic                          bad_end;
  } row_t;

  localparam row_t Rows [NumRows] = '{
    '{12'd4, 16'd0, 8'd0, 1'b0, 2'd0, 1'b0},
    '{12'd8, 16'd1, 8'd3, 1'b0, 2'd0, 1'b0},
    '{12'd64, 16'd2, 8'd1, 1'b0, 2'd0, 1'b0},
    '{12'd1, 16'd3, 8'd2, 1'b0, 2'd0, 1'b0},
    '{12'd2, 16'd4, 8'd0, 1'b0, 2'd0, 1'b0},
    '{12'd3, 16'd5, 8'd5, 1'b0, 2'd0, 1'b0},
    '{12'd5, 16'd6, 8'd1, 1'b0, 2'd0, 1'b0},
    '{12'd7, 16'd7, 8'd0, 1'b0, 2'd0, 1'b0},
    '{12'd8, 16'd8, 8'd2, 1'b1, 2'd0, 1'b0},
    '{12'd5, 16'd9, 8'd0, 1'b1, 2'd1, 1'b0},
    '{12'd16, 16'd10, 8'd1, 1'b1, 2'd2, 1'b0},
    '{12'd3, 16'd11, 8'd4, 1'b1, 2'd3, 1'b0},
    '{12'd6, 16'd12, 8'd0, 1'b0, 2'd0, 1'b1}
  };

  logic                          sd_clk;
  logic                          rst;
  logic [3:0]                    dat;
  logic                          start;
  logic [`SD_MAX_BLOCK_BITS-1:0] block_size;
  rx_word_t                      word;
  word_cnt_t                     word_count;
  rx_status_t                    status;
  logic                          card_busy;
  row_t                          cur_row;
  logic [7:0]                    block_bytes [MaxBytes];

  rx_word_t exp_words [$];
  int       exp_offsets [$];
  int       cycle_cnt = 0;
  int       start_edge = 0;
  logic     awaiting_start = 1'b0;
  int       seed;
  int       word_errors = 0;
  int       status_errors = 0;
  int       count_errors = 0;
  int       other_errors = 0;

  sd_dat_rx_top dut (
    .sd_clk_i     (sd_clk),
    .rst_i        (rst),
    .dat_i        (dat),
    .start_i      (start),
    .block_size_i (block_size),
    .word_o       (word),
    .word_count_o (word_count),
    .status_o     (status)
  );

  sd_card_model #(.MaxBytes(MaxBytes)) card (
    .clk_i      (sd_clk),
    .send_i     (start),
    .bytes_i    (block_bytes),
    .size_i     (int'(cur_row.size)),
    .gap_i      (int'(cur_row.gap)),
    .crc_flip_i (cur_row.crc_flip),
    .crc_line_i (cur_row.crc_line),
    .bad_end_i  (cur_row.bad_end),
    .dat_o      (dat),
    .busy_o     (card_busy)
  );

  initial begin
    sd_clk = 1'b0;
    forever #(ClkPeriod / 2) sd_clk = ~sd_clk;
  end

  always @(posedge sd_clk) cycle_cnt <= cycle_cnt + 1;

  task automatic check_word(input rx_word_t exp, input rx_word_t act);
    if (act !== exp) begin
      word_errors++;
      $display("MISMATCH %0t word_o expected %h actual %h", $time, exp, act);
    end
  endtask

  task automatic check_status(input rx_status_t exp, input rx_status_t act);
    if (act !== exp) begin
      status_errors++;
      $display("MISMATCH %0t status_o expected %b actual %b", $time, exp, act);
    end
  endtask

  task automatic check_count(input word_cnt_t exp, input word_cnt_t act);
    if (act !== exp) begin
      count_errors++;
      $display("MISMATCH %0t word_count_o expected %0d actual %0d", $time, exp, act);
    end
  endtask

  // Finds the start bit on the lines and checks every valid word against the queue
  always @(negedge sd_clk) begin : monitor
    int offset;
    if (!rst) begin
      if (awaiting_start && dat == 4'h0) begin
        start_edge     = cycle_cnt + 1;
        awaiting_start = 1'b0;
      end
      if (word.valid && exp_words.size() == 0) begin
        other_errors++;
        $display("%0t: word_o is valid while no word is expected", $time);
      end else if (word.valid) begin
        offset = exp_offsets.pop_front();
        check_word(exp_words.pop_front(), word);
        if (cycle_cnt - start_edge != offset) begin
          other_errors++;
          $display("%0t: word came %0d cycles after the start bit, expected %0d",
                   $time, cycle_cnt - start_edge, offset);
        end
      end
    end
  end

  task automatic run_block(input row_t row, inout rx_status_t prev_status,
                           inout word_cnt_t prev_count);
    rx_word_t   exp_word;
    rx_status_t exp_status;
    int         n;
    int         waited;
    n    = int'(row.size);
    seed = SeedBase + int'(row.seed);
    for (int k = 0; k < MaxBytes; k++) begin
      block_bytes[k] = (k < n) ? 8'($random(seed)) : 8'h00;
    end
    // Little-endian packing, a short last word is right aligned
    for (int k = 0; k < n; k += 4) begin
      exp_word       = '0;
      exp_word.valid = 1'b1;
      for (int j = 0; j < 4 && k + j < n; j++) begin
        exp_word.data[8*j +: 8] = block_bytes[k + j];
      end
      exp_words.push_back(exp_word);
      exp_offsets.push_back((k + 4 <= n) ? 2 * (k + 4) - 1 : 2 * n + 16);
    end
    exp_status = '{done: 1'b1, crc_err: row.crc_flip, end_bit_err: row.bad_end};

    // Previous result must still be held while idle
    repeat (3) @(negedge sd_clk);
    check_status(prev_status, status);
    check_count(prev_count, word_count);

    cur_row = row;
    @(posedge sd_clk);
    start      <= 1'b1;
    block_size <= row.size;
    @(posedge sd_clk);
    start          <= 1'b0;
    awaiting_start = 1'b1;
    @(negedge sd_clk);
    check_status('0, status);
    check_count('0, word_count);

    // Registered done rises one cycle after the done pulse
    waited = 0;
    while (!status.done && waited < 2 * n + int'(row.gap) + 24) begin
      @(negedge sd_clk);
      waited++;
    end
    if (!status.done) begin
      other_errors++;
      $display("%0t: status_o.done never rose for a %0d byte block", $time, n);
    end else if (cycle_cnt - start_edge != 2 * n + 17) begin
      other_errors++;
      $display("%0t: done came %0d cycles after the start bit, expected %0d",
               $time, cycle_cnt - start_edge, 2 * n + 17);
    end
    check_status(exp_status, status);
    check_count(word_cnt_t'((n + 3) / 4), word_count);

    // Card must be back on idle lines before the next block
    while (card_busy) @(negedge sd_clk);
    if (exp_words.size() != 0) begin
      other_errors++;
      $display("%0t: %0d expected words never arrived", $time, exp_words.size());
      exp_words.delete();
      exp_offsets.delete();
    end
    prev_status = exp_status;
    prev_count  = word_cnt_t'((n + 3) / 4);
  endtask

  initial begin : main
    rx_status_t prev_status;
    word_cnt_t  prev_count;
    int         total;
    rst        = 1'b1;
    start      = 1'b0;
    block_size = '0;
    cur_row    = '0;
    for (int k = 0; k < MaxBytes; k++) begin
      block_bytes[k] = 8'h00;
    end
    repeat (ResetCycles) @(posedge sd_clk);
    rst <= 1'b0;
    @(negedge sd_clk);
    check_word('0, word);
    check_status('0, status);
    check_count('0, word_count);
    prev_status = '0;
    prev_count  = '0;
    for (int r = 0; r < NumRows; r++) begin
      run_block(Rows[r], prev_status, prev_count);
    end
    total = word_errors + status_errors + count_errors + other_errors;
    $display("Errors: word %0d, status %0d, count %0d, other %0d",
             word_errors, status_errors, count_errors, other_errors);
    if (total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    limit = ResetCycles;
    for (int r = 0; r < NumRows; r++) begin
      limit += 2 * int'(Rows[r].size) + int'(Rows[r].gap) + 40;
    end
    repeat (limit) @(posedge sd_clk);
    $display("Timeout after %0d cycles, the blocks did not all complete", limit);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
